//--- adapter_trace.txt
# U store size addr wdata d_data a_mask a_data rdata
# P addr cap tag_way0 tag_way1 tag_way2 tag_way3 sram_line c_opcode c_param c_data tag_we tag_wdata
U 0 2 80001004 00000000 dddd0003cccc0002bbbb0001aaaa0000 00f0 0 bbbb0001
U 1 2 1000400c deadbeef 0 f000 deadbeef000000000000000000000000 0
P 80001230 1 048d17 000000 200007 200004 0123456789abcdeffedcba9876543210 5 0 0123456789abcdeffedcba9876543210 4 200005
U 0 0 8000200b 00000000 dddd0003cccc0002bbbb0001aaaa0000 0800 0 cccc0002
P 4567a8f0 2 1159eb 1159e8 048d17 000000 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 5 1 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 1 0
U 1 0 10005001 a5a5a5a5 0 0002 000000000000000000000000a5a5a5a5 0
P 80001230 1 000000 200005 048d15 000000 ffffffffffffffffffffffffffffffff 4 4 0 2 200005
U 0 1 0000300e 00000000 dddd0003cccc0002bbbb0001aaaa0000 c000 0 dddd0003
P 12345670 2 200007 000000 000000 048d15 ffffffffffffffffffffffffffffffff 4 2 0 8 0
U 1 1 10006006 12341234 0 00c0 00000000000000001234123400000000 0
P 0badc0d0 1 02eb70 200007 048d17 02eb72 ffffffffffffffffffffffffffffffff 4 5 0 0 0
U 0 2 20000000 00000000 dddd0003cccc0002bbbb0001aaaa0000 000f 0 aaaa0000
P 7fff0000 2 000000 000000 000000 000000 ffffffffffffffffffffffffffffffff 4 5 0 0 0

//--- dcache_tl_adapter.sv
// dcache tilelink adapter top, uncached access on a/d and probe service on b/c
module dcache_tl_adapter (
    input  logic                      clk,
    input  logic                      rst_n,
    // cpu side
    input  dcache_tl_pkg::cpu_req_t   cpu_req_i,
    output dcache_tl_pkg::cpu_resp_t  cpu_resp_o,
    // tilelink channels
    output logic                      a_valid_o,
    input  logic                      a_ready_i,
    output dcache_tl_pkg::tl_a_t      a_o,
    input  logic                      b_valid_i,
    output logic                      b_ready_o,
    input  dcache_tl_pkg::tl_b_t      b_i,
    output logic                      c_valid_o,
    input  logic                      c_ready_i,
    output dcache_tl_pkg::tl_c_t      c_o,
    input  logic                      d_valid_i,
    output logic                      d_ready_o,
    input  dcache_tl_pkg::tl_d_t      d_i,
    // tag sram
    output logic                      t_en_o,
    output dcache_tl_pkg::set_idx_t   t_addr_o,
    output dcache_tl_pkg::way_mask_t  t_we_o,
    output dcache_tl_pkg::cache_tag_t t_wtag_o,
    input  dcache_tl_pkg::cache_tag_t [dcache_tl_pkg::NUM_WAYS-1:0] t_rtag_i,
    // data sram, read only here
    output logic                      m_en_o,
    output dcache_tl_pkg::way_t       m_way_o,
    output dcache_tl_pkg::set_idx_t   m_set_o,
    input  dcache_tl_pkg::line_t      m_rdata_i
);

    // uncached path owns a and d
    uncached_access uncached_access_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req_i  (cpu_req_i),
        .cpu_resp_o (cpu_resp_o),
        .a_valid_o  (a_valid_o),
        .a_ready_i  (a_ready_i),
        .a_o        (a_o),
        .d_valid_i  (d_valid_i),
        .d_ready_o  (d_ready_o),
        .d_i        (d_i)
    );

    // probe path owns b, c and both sram ports
    probe_handler probe_handler_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .b_valid_i (b_valid_i),
        .b_ready_o (b_ready_o),
        .b_i       (b_i),
        .c_valid_o (c_valid_o),
        .c_ready_i (c_ready_i),
        .c_o       (c_o),
        .t_en_o    (t_en_o),
        .t_addr_o  (t_addr_o),
        .t_we_o    (t_we_o),
        .t_wtag_o  (t_wtag_o),
        .t_rtag_i  (t_rtag_i),
        .m_en_o    (m_en_o),
        .m_way_o   (m_way_o),
        .m_set_o   (m_set_o),
        .m_rdata_i (m_rdata_i)
    );

endmodule

//--- dcache_tl_pkg.sv
// shared widths, tilelink encodings and channel structs of the dcache bus adapter
package dcache_tl_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int TL_OPCODE_W    = 3;
    localparam int TL_PARAM_W     = 3;
    localparam int LINE_SIZE_LOG2 = 4;   // 16 byte lines, one beat

    typedef logic [31:0]           paddr_t;
    typedef logic [11:4]           set_idx_t;
    typedef logic [1:0]            way_t;
    typedef logic [NUM_WAYS-1:0]   way_mask_t;
    typedef logic [31:12]          ptag_t;
    typedef logic [31:0]           word_t;
    typedef logic [127:0]          line_t;
    typedef logic [15:0]           byte_mask_t;
    typedef logic [2:0]            tl_size_t;
    typedef logic [0:0]            tl_source_t;
    typedef logic [0:0]            tl_sink_t;

    localparam tl_source_t ADAPTER_SOURCE = 1'b0;

    // opcodes per channel
    localparam logic [TL_OPCODE_W-1:0] PUT_PARTIAL_DATA = 3'd1;  // a
    localparam logic [TL_OPCODE_W-1:0] GET              = 3'd4;  // a
    localparam logic [TL_OPCODE_W-1:0] PROBE_BLOCK      = 3'd6;  // b
    localparam logic [TL_OPCODE_W-1:0] PROBE_ACK        = 3'd4;  // c
    localparam logic [TL_OPCODE_W-1:0] PROBE_ACK_DATA   = 3'd5;  // c
    localparam logic [TL_OPCODE_W-1:0] ACCESS_ACK       = 3'd0;  // d
    localparam logic [TL_OPCODE_W-1:0] ACCESS_ACK_DATA  = 3'd1;  // d

    // cap params carried by a probe
    localparam logic [TL_PARAM_W-1:0] PARAM_TO_T = 3'd0;
    localparam logic [TL_PARAM_W-1:0] PARAM_TO_B = 3'd1;
    localparam logic [TL_PARAM_W-1:0] PARAM_TO_N = 3'd2;

    // shrink and report params on c
    localparam logic [TL_PARAM_W-1:0] TTOB = 3'd0;
    localparam logic [TL_PARAM_W-1:0] TTON = 3'd1;
    localparam logic [TL_PARAM_W-1:0] BTON = 3'd2;
    localparam logic [TL_PARAM_W-1:0] TTOT = 3'd3;
    localparam logic [TL_PARAM_W-1:0] BTOB = 3'd4;
    localparam logic [TL_PARAM_W-1:0] NTON = 3'd5;

    typedef struct packed {
        ptag_t p;
        logic  wp;   // write permission, trunk
        logic  rp;   // read permission, branch or trunk
    } cache_tag_t;

    typedef struct packed {
        logic [TL_OPCODE_W-1:0] opcode;
        logic [TL_PARAM_W-1:0]  param;
        tl_size_t               size;
        tl_source_t             source;
        paddr_t                 address;
        byte_mask_t             mask;
        line_t                  data;
        logic                   corrupt;
    } tl_a_t;

    typedef struct packed {
        logic [TL_OPCODE_W-1:0] opcode;
        logic [TL_PARAM_W-1:0]  param;
        tl_size_t               size;
        tl_source_t             source;
        paddr_t                 address;
    } tl_b_t;

    typedef struct packed {
        logic [TL_OPCODE_W-1:0] opcode;
        logic [TL_PARAM_W-1:0]  param;
        tl_size_t               size;
        tl_source_t             source;
        paddr_t                 address;
        line_t                  data;
    } tl_c_t;

    typedef struct packed {
        logic [TL_OPCODE_W-1:0] opcode;
        logic [TL_PARAM_W-1:0]  param;
        tl_size_t               size;
        tl_source_t             source;
        tl_sink_t               sink;
        line_t                  data;
    } tl_d_t;

    typedef struct packed {
        logic       valid;
        logic       store;
        logic [1:0] size;    // log2 bytes, 0 to 2
        paddr_t     addr;
        word_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_resp_t;

endpackage

//--- probe_handler.sv
// probe service, looks up and downgrades the tag and answers the b-channel probe on c
module probe_handler (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     b_valid_i,
    output logic                     b_ready_o,
    input  dcache_tl_pkg::tl_b_t     b_i,
    output logic                     c_valid_o,
    input  logic                     c_ready_i,
    output dcache_tl_pkg::tl_c_t     c_o,
    output logic                     t_en_o,
    output dcache_tl_pkg::set_idx_t  t_addr_o,
    output dcache_tl_pkg::way_mask_t t_we_o,
    output dcache_tl_pkg::cache_tag_t t_wtag_o,
    input  dcache_tl_pkg::cache_tag_t [dcache_tl_pkg::NUM_WAYS-1:0] t_rtag_i,
    output logic                     m_en_o,
    output dcache_tl_pkg::way_t      m_way_o,
    output dcache_tl_pkg::set_idx_t  m_set_o,
    input  dcache_tl_pkg::line_t     m_rdata_i
);

    typedef enum logic [2:0] {
        IDLE,
        READ_TAG,
        MATCH,
        READ_DATA,
        FETCH_DATA,
        SEND_C
    } prb_state_e;

    prb_state_e                          state_q;
    dcache_tl_pkg::paddr_t               addr_q;
    logic [dcache_tl_pkg::TL_PARAM_W-1:0] cap_q;
    dcache_tl_pkg::way_t                 way_q;
    logic                                wp_q;    // line was trunk
    logic                                rp_q;    // line was present
    dcache_tl_pkg::line_t                data_q;

    dcache_tl_pkg::way_mask_t            hit_vec;
    dcache_tl_pkg::way_t                 hit_way;
    logic                                hit;
    dcache_tl_pkg::cache_tag_t           hit_tag;

    // tag compare on the set returned by the read
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int i = 0; i < dcache_tl_pkg::NUM_WAYS; i++) begin
            hit_vec[i] = t_rtag_i[i].rp && (t_rtag_i[i].p == addr_q[31:12]);
        end
        for (int i = dcache_tl_pkg::NUM_WAYS - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_way = dcache_tl_pkg::way_t'(i);   // lowest way wins
            end
        end
    end

    assign hit     = |hit_vec;
    assign hit_tag = t_rtag_i[hit_way];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (b_valid_i) begin
                        state_q <= READ_TAG;
                    end
                end
                READ_TAG: begin
                    state_q <= MATCH;
                end
                MATCH: begin
                    state_q <= (hit && hit_tag.wp) ? READ_DATA : SEND_C;
                end
                READ_DATA: begin
                    state_q <= FETCH_DATA;
                end
                FETCH_DATA: begin
                    state_q <= SEND_C;
                end
                default: begin
                    if (c_ready_i) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && b_valid_i) begin
            addr_q <= b_i.address;
            cap_q  <= b_i.param;
        end
        if (state_q == MATCH) begin
            way_q <= hit_way;
            wp_q  <= hit && hit_tag.wp;
            rp_q  <= hit;
        end
        if (state_q == FETCH_DATA) begin
            data_q <= m_rdata_i;
        end
    end

    // tag sram, read in READ_TAG and downgrade in MATCH
    always_comb begin
        t_en_o   = (state_q == READ_TAG);
        t_we_o   = '0;
        t_wtag_o = '0;
        if (state_q == MATCH && hit && cap_q != dcache_tl_pkg::PARAM_TO_T) begin
            t_en_o          = 1'b1;
            t_we_o[hit_way] = 1'b1;
            if (cap_q == dcache_tl_pkg::PARAM_TO_B) begin
                t_wtag_o.p  = hit_tag.p;
                t_wtag_o.rp = 1'b1;   // keep a read-only copy
            end
        end
    end

    assign t_addr_o = addr_q[11:4];
    assign m_en_o   = (state_q == READ_DATA);
    assign m_way_o  = way_q;
    assign m_set_o  = addr_q[11:4];

    // c beat, report param from old permission and cap
    always_comb begin
        c_o         = '0;
        c_o.opcode  = wp_q ? dcache_tl_pkg::PROBE_ACK_DATA : dcache_tl_pkg::PROBE_ACK;
        c_o.size    = dcache_tl_pkg::tl_size_t'(dcache_tl_pkg::LINE_SIZE_LOG2);
        c_o.source  = dcache_tl_pkg::ADAPTER_SOURCE;
        c_o.address = {addr_q[31:4], 4'd0};
        c_o.data    = wp_q ? data_q : '0;
        case (cap_q)
            dcache_tl_pkg::PARAM_TO_B: begin
                c_o.param = wp_q ? dcache_tl_pkg::TTOB :
                            (rp_q ? dcache_tl_pkg::BTOB : dcache_tl_pkg::NTON);
            end
            dcache_tl_pkg::PARAM_TO_T: begin
                c_o.param = wp_q ? dcache_tl_pkg::TTOT :
                            (rp_q ? dcache_tl_pkg::BTOB : dcache_tl_pkg::NTON);
            end
            default: begin
                c_o.param = wp_q ? dcache_tl_pkg::TTON :
                            (rp_q ? dcache_tl_pkg::BTON : dcache_tl_pkg::NTON);
            end
        endcase
    end

    assign b_ready_o = (state_q == IDLE);
    assign c_valid_o = (state_q == SEND_C);

    // the cache never holds one line in two ways
    assert property (@(posedge clk) disable iff (!rst_n)
        state_q == MATCH |-> $onehot0(hit_vec));

    assert property (@(posedge clk) disable iff (!rst_n)
        c_valid_o && !c_ready_i |=> c_valid_o && $stable(c_o));

    // tag write lands on the set read the cycle before
    assert property (@(posedge clk) disable iff (!rst_n)
        t_we_o != '0 |-> $past(t_en_o) && $past(t_we_o) == '0 && $stable(t_addr_o));

endmodule

//--- run.sh
#!/bin/sh
# build the adapter testbench with verilator, run it and look for the pass line
verilator --binary --timing --assert --top-module tb_dcache_tl_adapter -f sources.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_dcache_tl_adapter)
echo "$out"
echo "$out" | grep -qx '>>> PASS' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sources.f
dcache_tl_pkg.sv
uncached_access.sv
probe_handler.sv
dcache_tl_adapter.sv
tb_clock_gen.sv
tb_dcache_tl_adapter.sv

//--- tb_clock_gen.sv
// testbench clock and reset source, 100 unit period and a 4 cycle reset pulse
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;   // released away from the edge
    end

endmodule

//--- tb_dcache_tl_adapter.sv
// testbench for the dcache tilelink adapter, plays the trace against sram and manager models
module tb_dcache_tl_adapter;

    typedef struct packed {
        logic                            is_probe;
        logic                            store;
        logic [1:0]                      size;
        dcache_tl_pkg::paddr_t           addr;
        dcache_tl_pkg::word_t            wdata;
        dcache_tl_pkg::line_t            line;     // d beat data or data sram line
        dcache_tl_pkg::byte_mask_t       mask;
        dcache_tl_pkg::line_t            adata;
        dcache_tl_pkg::word_t            rdata;
        logic [2:0]                      cap;
        dcache_tl_pkg::cache_tag_t [3:0] tags;
        logic [2:0]                      c_opcode;
        logic [2:0]                      c_param;
        dcache_tl_pkg::line_t            cdata;
        dcache_tl_pkg::way_mask_t        we;
        dcache_tl_pkg::cache_tag_t       wtag;
    } trace_vec_t;

    logic                            clk;
    logic                            rst_n;
    dcache_tl_pkg::cpu_req_t         cpu_req;
    dcache_tl_pkg::cpu_resp_t        cpu_resp;
    logic                            a_valid;
    logic                            a_ready;
    logic                            b_valid;
    logic                            b_ready;
    logic                            c_valid;
    logic                            c_ready;
    logic                            d_valid;
    logic                            d_ready;
    dcache_tl_pkg::tl_a_t            a;
    dcache_tl_pkg::tl_b_t            b;
    dcache_tl_pkg::tl_c_t            c;
    dcache_tl_pkg::tl_d_t            d;
    logic                            t_en;
    dcache_tl_pkg::set_idx_t         t_addr;
    dcache_tl_pkg::way_mask_t        t_we;
    dcache_tl_pkg::cache_tag_t       t_wtag;
    dcache_tl_pkg::cache_tag_t [3:0] t_rtag;
    logic                            m_en;
    dcache_tl_pkg::way_t             m_way;
    dcache_tl_pkg::set_idx_t         m_set;
    dcache_tl_pkg::line_t            m_rdata;

    trace_vec_t                      vecs[$];
    dcache_tl_pkg::cache_tag_t [3:0] tags_cur = '0;
    dcache_tl_pkg::line_t            line_cur = '0;
    int                              errors = 0;
    int                              n_pass = 0;
    int                              n_fail = 0;
    int                              done_count = 0;
    int                              cycles = 0;
    int                              cycle_limit = 0;
    // seen by the sram model
    int                              tag_reads = 0;
    int                              tag_writes = 0;
    int                              data_reads = 0;
    logic                            tag_pend;
    logic                            data_pend;
    dcache_tl_pkg::set_idx_t         last_tag_set;
    dcache_tl_pkg::set_idx_t         last_data_set;
    dcache_tl_pkg::way_t             last_data_way;
    dcache_tl_pkg::way_mask_t        last_we;
    dcache_tl_pkg::cache_tag_t       last_wtag;

    tb_clock_gen clock_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dcache_tl_adapter dcache_tl_adapter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req_i  (cpu_req),
        .cpu_resp_o (cpu_resp),
        .a_valid_o  (a_valid),
        .a_ready_i  (a_ready),
        .a_o        (a),
        .b_valid_i  (b_valid),
        .b_ready_o  (b_ready),
        .b_i        (b),
        .c_valid_o  (c_valid),
        .c_ready_i  (c_ready),
        .c_o        (c),
        .d_valid_i  (d_valid),
        .d_ready_o  (d_ready),
        .d_i        (d),
        .t_en_o     (t_en),
        .t_addr_o   (t_addr),
        .t_we_o     (t_we),
        .t_wtag_o   (t_wtag),
        .t_rtag_i   (t_rtag),
        .m_en_o     (m_en),
        .m_way_o    (m_way),
        .m_set_o    (m_set),
        .m_rdata_i  (m_rdata)
    );

    // tag and data sram, read data one cycle after the request
    initial begin
        t_rtag    = '0;
        m_rdata   = '0;
        tag_pend  = 1'b0;
        data_pend = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            t_rtag  = tag_pend ? tags_cur : '0;
            m_rdata = data_pend ? line_cur : '0;
            #50;   // mid cycle, requests have settled
            tag_pend  = t_en && t_we == '0;
            data_pend = m_en;
            if (tag_pend) begin
                tag_reads++;
                last_tag_set = t_addr;
            end
            if (t_en && t_we != '0) begin
                tag_writes++;
                last_we   = t_we;
                last_wtag = t_wtag;
            end
            if (m_en) begin
                data_reads++;
                last_data_set = m_set;
                last_data_way = m_way;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // way number of a one hot way mask
    function automatic dcache_tl_pkg::way_t mask_to_way(input dcache_tl_pkg::way_mask_t wm);
        dcache_tl_pkg::way_t w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            if (wm[i]) begin
                w = dcache_tl_pkg::way_t'(i);
            end
        end
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #10;
        if (cpu_resp.done) begin
            done_count++;
        end
    endtask

    task automatic mismatch(input string name, input logic [127:0] got, input logic [127:0] exp);
        $display("Fail %s: got %0h, expected %0h", name, got, exp);
        errors++;
    endtask

    task automatic complain(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic run_uncached(input trace_vec_t v);
        dcache_tl_pkg::tl_a_t held;
        int unsigned          wait_a;
        int unsigned          wait_d;
        logic [2:0]           exp_op;
        wait_a = $urandom % 4;
        wait_d = $urandom % 4;
        exp_op = v.store ? dcache_tl_pkg::PUT_PARTIAL_DATA : dcache_tl_pkg::GET;
        done_count = 0;
        cpu_req.valid = 1'b1;
        cpu_req.store = v.store;
        cpu_req.size  = v.size;
        cpu_req.addr  = v.addr;
        cpu_req.wdata = v.wdata;
        tick();
        while (!a_valid) begin
            tick();
        end
        held = a;
        if (a.opcode !== exp_op) mismatch("a_o.opcode", 128'(a.opcode), 128'(exp_op));
        if (a.address !== v.addr) mismatch("a_o.address", 128'(a.address), 128'(v.addr));
        if (a.mask !== v.mask) mismatch("a_o.mask", 128'(a.mask), 128'(v.mask));
        if (a.data !== v.adata) mismatch("a_o.data", a.data, v.adata);
        if (a.size !== {1'b0, v.size}) mismatch("a_o.size", 128'(a.size), 128'(v.size));
        repeat (wait_a) begin
            tick();
            if (!a_valid || a !== held) complain("a beat changed while waiting for a_ready");
        end
        a_ready = 1'b1;
        tick();
        a_ready = 1'b0;
        repeat (wait_d) begin
            tick();
        end
        if (!d_ready) complain("d_ready is low while the d beat is awaited");
        d_valid = 1'b1;
        d.opcode = v.store ? dcache_tl_pkg::ACCESS_ACK : dcache_tl_pkg::ACCESS_ACK_DATA;
        d.size   = {1'b0, v.size};
        d.data   = v.line;
        tick();
        d_valid = 1'b0;
        d = '0;
        if (!cpu_resp.done) begin
            complain("done did not follow the d beat");
        end else if (!v.store && cpu_resp.rdata !== v.rdata) begin
            mismatch("cpu_resp_o.rdata", 128'(cpu_resp.rdata), 128'(v.rdata));
        end
        cpu_req = '0;   // cpu drops the request after done
        tick();
        if (done_count != 1) complain($sformatf("done pulsed %0d times", done_count));
    endtask

    task automatic run_probe(input trace_vec_t v);
        dcache_tl_pkg::tl_c_t held;
        int unsigned          wait_c;
        int                   reads0;
        int                   writes0;
        int                   dreads0;
        wait_c   = $urandom % 4;
        tags_cur = v.tags;
        line_cur = v.line;
        reads0   = tag_reads;
        writes0  = tag_writes;
        dreads0  = data_reads;
        if (!b_ready) complain("b_ready is low while the probe handler is idle");
        b_valid   = 1'b1;
        b.opcode  = dcache_tl_pkg::PROBE_BLOCK;
        b.param   = v.cap;
        b.size    = dcache_tl_pkg::tl_size_t'(dcache_tl_pkg::LINE_SIZE_LOG2);
        b.source  = dcache_tl_pkg::ADAPTER_SOURCE;
        b.address = v.addr;
        tick();
        b_valid = 1'b0;
        b = '0;
        while (!c_valid) begin
            if (b_ready) complain("b_ready rose before the c transfer");
            tick();
        end
        held = c;
        if (c.opcode !== v.c_opcode) mismatch("c_o.opcode", 128'(c.opcode), 128'(v.c_opcode));
        if (c.param !== v.c_param) mismatch("c_o.param", 128'(c.param), 128'(v.c_param));
        if (c.data !== v.cdata) mismatch("c_o.data", c.data, v.cdata);
        if (c.address !== {v.addr[31:4], 4'd0}) begin
            mismatch("c_o.address", 128'(c.address), 128'({v.addr[31:4], 4'd0}));
        end
        repeat (wait_c) begin
            tick();
            if (!c_valid || c !== held || b_ready) complain("c beat changed while stalled");
        end
        c_ready = 1'b1;
        tick();
        c_ready = 1'b0;
        if (!b_ready || c_valid) complain("probe handler did not return to idle");
        if (tag_reads - reads0 != 1) complain("probe did not read the tag set exactly once");
        if (last_tag_set !== v.addr[11:4]) begin
            mismatch("t_addr_o", 128'(last_tag_set), 128'(v.addr[11:4]));
        end
        if (v.we == '0) begin
            if (tag_writes != writes0) complain("tag was written although none was expected");
        end else begin
            if (tag_writes - writes0 != 1) complain("tag was not written exactly once");
            if (last_we !== v.we) mismatch("t_we_o", 128'(last_we), 128'(v.we));
            if (last_wtag !== v.wtag) mismatch("t_wtag_o", 128'(last_wtag), 128'(v.wtag));
        end
        if (v.c_opcode == dcache_tl_pkg::PROBE_ACK_DATA) begin
            if (data_reads - dreads0 != 1) complain("line was not read from data sram once");
            if (last_data_set !== v.addr[11:4]) begin
                mismatch("m_set_o", 128'(last_data_set), 128'(v.addr[11:4]));
            end
            if (v.we != '0 && last_data_way !== mask_to_way(v.we)) begin
                mismatch("m_way_o", 128'(last_data_way), 128'(mask_to_way(v.we)));
            end
        end else if (data_reads != dreads0) begin
            complain("data sram was read for a line without write permission");
        end
    endtask

    initial begin
        trace_vec_t                v;
        string                     text;
        int                        fd;
        int                        n;
        int                        errs0;
        logic                      st;
        logic [1:0]                sz;
        dcache_tl_pkg::paddr_t     addr;
        dcache_tl_pkg::word_t      wdata;
        dcache_tl_pkg::word_t      rdata;
        dcache_tl_pkg::line_t      ln;
        dcache_tl_pkg::line_t      ln2;
        dcache_tl_pkg::byte_mask_t mask;
        logic [2:0]                cap;
        logic [2:0]                copc;
        logic [2:0]                cpar;
        logic [21:0]               tg0;
        logic [21:0]               tg1;
        logic [21:0]               tg2;
        logic [21:0]               tg3;
        logic [21:0]               wtag;
        logic [3:0]                we;
        void'($urandom(32'had52));
        cpu_req = '0;
        a_ready = 1'b0;
        b_valid = 1'b0;
        b       = '0;
        c_ready = 1'b0;
        d_valid = 1'b0;
        d       = '0;
        fd = $fopen("adapter_trace.txt", "r");
        if (fd == 0) begin
            complain("could not open adapter_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                v = '0;
                if (n > 0 && text.getc(0) == "U") begin
                    n = $sscanf(text, "U %h %h %h %h %h %h %h %h",
                                st, sz, addr, wdata, ln, mask, ln2, rdata);
                    if (n != 8) complain($sformatf("malformed trace line: %s", text));
                    v.store = st;
                    v.size  = sz;
                    v.addr  = addr;
                    v.wdata = wdata;
                    v.line  = ln;
                    v.mask  = mask;
                    v.adata = ln2;
                    v.rdata = rdata;
                    vecs.push_back(v);
                end else if (n > 0 && text.getc(0) == "P") begin
                    n = $sscanf(text, "P %h %h %h %h %h %h %h %h %h %h %h %h",
                                addr, cap, tg0, tg1, tg2, tg3, ln, copc, cpar, ln2, we, wtag);
                    if (n != 12) complain($sformatf("malformed trace line: %s", text));
                    v.is_probe = 1'b1;
                    v.addr     = addr;
                    v.cap      = cap;
                    v.tags     = {tg3, tg2, tg1, tg0};
                    v.line     = ln;
                    v.c_opcode = copc;
                    v.c_param  = cpar;
                    v.cdata    = ln2;
                    v.we       = we;
                    v.wtag     = wtag;
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
            if (vecs.size() == 0) complain("trace file holds no tests");
        end
        cycle_limit = 40 * vecs.size() + 20;
        wait (rst_n);
        tick();
        foreach (vecs[i]) begin
            errs0 = errors;
            if (vecs[i].is_probe) begin
                run_probe(vecs[i]);
            end else begin
                run_uncached(vecs[i]);
            end
            if (errors == errs0) begin
                n_pass++;
                $display("test %0d (%s) ok", i,
                         vecs[i].is_probe ? "probe" : (vecs[i].store ? "store" : "load"));
            end else begin
                n_fail++;
                $display("test %0d (%s) failed", i,
                         vecs[i].is_probe ? "probe" : (vecs[i].store ? "store" : "load"));
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 vecs.size(), n_pass, n_fail, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- uncached_access.sv
// uncached access engine, turns one cpu load or store into one tilelink a/d transaction
module uncached_access (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dcache_tl_pkg::cpu_req_t  cpu_req_i,
    output dcache_tl_pkg::cpu_resp_t cpu_resp_o,
    output logic                     a_valid_o,
    input  logic                     a_ready_i,
    output dcache_tl_pkg::tl_a_t     a_o,
    input  logic                     d_valid_i,
    output logic                     d_ready_o,
    input  dcache_tl_pkg::tl_d_t     d_i
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_A,
        WAIT_D,
        RESPOND
    } unc_state_e;

    unc_state_e               state_q;
    dcache_tl_pkg::cpu_req_t  req_q;
    dcache_tl_pkg::word_t     rdata_q;
    logic [6:0]               lane_base;   // bit offset of the addressed word in the beat

    assign lane_base = {req_q.addr[3:2], 5'd0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cpu_req_i.valid) begin
                        state_q <= SEND_A;
                    end
                end
                SEND_A: begin
                    if (a_ready_i) begin
                        state_q <= WAIT_D;
                    end
                end
                WAIT_D: begin
                    if (d_valid_i) begin
                        state_q <= RESPOND;
                    end
                end
                default: begin
                    state_q <= IDLE;   // done pulses for this one cycle
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_req_i.valid) begin
            req_q <= cpu_req_i;
        end
        if (state_q == WAIT_D && d_valid_i) begin
            rdata_q <= d_i.data[lane_base +: 32];
        end
    end

    // a beat built from the held request
    always_comb begin
        dcache_tl_pkg::byte_mask_t size_mask;
        case (req_q.size)
            2'd0:    size_mask = 16'h0001;
            2'd1:    size_mask = 16'h0003;
            default: size_mask = 16'h000f;
        endcase
        a_o         = '0;
        a_o.opcode  = req_q.store ? dcache_tl_pkg::PUT_PARTIAL_DATA : dcache_tl_pkg::GET;
        a_o.size    = {1'b0, req_q.size};
        a_o.source  = dcache_tl_pkg::ADAPTER_SOURCE;
        a_o.address = req_q.addr;
        a_o.mask    = size_mask << req_q.addr[3:0];
        if (req_q.store) begin
            a_o.data[lane_base +: 32] = req_q.wdata;
        end
        a_o.corrupt = 1'b0;
    end

    assign a_valid_o        = (state_q == SEND_A);
    assign d_ready_o        = (state_q == WAIT_D);
    assign cpu_resp_o.done  = (state_q == RESPOND);
    assign cpu_resp_o.rdata = rdata_q;

    // manager sees a steady a beat until it takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        a_valid_o && !a_ready_i |=> a_valid_o && $stable(a_o));

    // cpu side only issues naturally aligned accesses
    assert property (@(posedge clk) disable iff (!rst_n)
        state_q == IDLE && cpu_req_i.valid |->
            cpu_req_i.size == 2'd0 ||
            (cpu_req_i.size == 2'd1 && !cpu_req_i.addr[0]) ||
            (cpu_req_i.size == 2'd2 && cpu_req_i.addr[1:0] == 2'b00));

endmodule
